/* hdl/roach_pkg.sv */
package roach_pkg;

  // bus widths
  localparam int WB_ADDR_W = 32;
  localparam int WB_DATA_W = 16;

  // address map
  localparam int NUM_SLAVES = 2;
  localparam int SLAVE_SYS  = 0;
  localparam int SLAVE_MEM  = 1;

  localparam logic [WB_ADDR_W-1:0] SLAVE_BASE [NUM_SLAVES] = '{
    32'h0000_0000, // sys_block
    32'h0008_0000  // boot memory
  };

  localparam logic [WB_ADDR_W-1:0] SLAVE_HIGH [NUM_SLAVES] = '{
    32'h0000_ffff,
    32'h0008_ffff
  };

  // serial commands
  localparam logic [7:0] CMD_READ  = 8'h01;
  localparam logic [7:0] CMD_WRITE = 8'h02;
  localparam logic [7:0] CMD_RESET = 8'h03;

  // response status
  localparam logic [7:0] ST_OK      = 8'h00;
  localparam logic [7:0] ST_BUS_ERR = 8'hff;
  localparam logic [7:0] ST_BAD_CMD = 8'hee;

  // sys_block word offsets
  localparam logic [2:0] REG_BOARD_ID  = 3'd0;
  localparam logic [2:0] REG_REV_MAJOR = 3'd1;
  localparam logic [2:0] REG_REV_MINOR = 3'd2;
  localparam logic [2:0] REG_REV_RCS   = 3'd3;
  localparam logic [2:0] REG_SCRATCH   = 3'd4;

endpackage

/* hdl/wb_if.sv */
interface wb_if;
  import roach_pkg::*;

  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [WB_ADDR_W-1:0] adr;
  logic [WB_DATA_W-1:0] wdat;
  logic [WB_DATA_W-1:0] rdat;
  logic                 ack;
  logic                 err;

  modport master (
    output cyc, stb, we, adr, wdat,
    input  rdat, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, wdat,
    output rdat, ack, err
  );

endinterface

/* hdl/as_if.sv */
interface as_if;
  logic [7:0] tx_data;
  logic       tx_dstrb;
  logic       tx_busy;
  logic [7:0] rx_data;
  logic       rx_dstrb;

  // uart side of the byte stream
  modport uart (input tx_data, tx_dstrb, output tx_busy, rx_data, rx_dstrb);

  modport host (output tx_data, tx_dstrb, input tx_busy, rx_data, rx_dstrb);

endinterface

/* hdl/reset_block.sv */
module reset_block #(
  parameter int RESET_DELAY = 32
) (
  input  logic sys_clk,
  input  logic rst_i,
  input  logic reset_req_i,
  output logic sys_reset_o
);

  localparam int CNT_W = $clog2(RESET_DELAY + 1);

  logic [CNT_W-1:0] cnt;

  always_ff @(posedge sys_clk) begin
    if (rst_i || reset_req_i) begin
      cnt <= CNT_W'(RESET_DELAY); // reload on every request
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  assign sys_reset_o = rst_i | reset_req_i | (cnt != '0);

endmodule

/* hdl/serial_uart.sv */
module serial_uart #(
  parameter int CLOCK_RATE = 100_000_000,
  parameter int BAUD       = 115_200
) (
  input  logic sys_clk,
  input  logic rst_i,
  input  logic serial_in_i,
  output logic serial_out_o,
  as_if.uart   as_bus
);

  localparam int CLKS_PER_BIT = CLOCK_RATE / BAUD;
  localparam int CNT_W        = $clog2(CLKS_PER_BIT);

  logic [9:0]       tx_shift; // stop, data, start
  logic [CNT_W-1:0] tx_cnt;
  logic [3:0]       tx_bit;
  logic             tx_busy;

  logic [2:0]       rx_sync;
  logic [CNT_W-1:0] rx_cnt;
  logic [3:0]       rx_bit;
  logic             rx_active;
  logic [7:0]       rx_shift;
  logic             rx_dstrb;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      tx_shift <= '1;
      tx_cnt   <= '0;
      tx_bit   <= '0;
      tx_busy  <= 1'b0;
    end else if (!tx_busy) begin
      if (as_bus.tx_dstrb) begin
        tx_shift <= {1'b1, as_bus.tx_data, 1'b0};
        tx_cnt   <= '0;
        tx_bit   <= '0;
        tx_busy  <= 1'b1;
      end
    end else if (tx_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
      tx_cnt   <= '0;
      tx_shift <= {1'b1, tx_shift[9:1]};
      if (tx_bit == 4'd9) begin
        tx_busy <= 1'b0; // end of stop bit
      end else begin
        tx_bit <= tx_bit + 1'b1;
      end
    end else begin
      tx_cnt <= tx_cnt + 1'b1;
    end
  end

  assign serial_out_o   = tx_shift[0];
  assign as_bus.tx_busy = tx_busy;

  // rx_sync[1] is the synchronized line, rx_sync[2] its previous value
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      rx_sync   <= 3'b111;
      rx_cnt    <= '0;
      rx_bit    <= '0;
      rx_active <= 1'b0;
      rx_dstrb  <= 1'b0;
    end else begin
      rx_sync  <= {rx_sync[1:0], serial_in_i};
      rx_dstrb <= 1'b0;
      if (!rx_active) begin
        if (rx_sync[2] && !rx_sync[1]) begin
          rx_active <= 1'b1;
          rx_cnt    <= CNT_W'(CLKS_PER_BIT / 2 - 1); // land on mid-bit
          rx_bit    <= '0;
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - 1'b1;
      end else begin
        rx_cnt <= CNT_W'(CLKS_PER_BIT - 1);
        rx_bit <= rx_bit + 1'b1;
        if (rx_bit == 4'd0) begin
          if (rx_sync[1]) rx_active <= 1'b0; // glitch, not a start bit
        end else if (rx_bit == 4'd9) begin
          rx_active <= 1'b0;
          rx_dstrb  <= rx_sync[1]; // framing error drops the byte
        end else begin
          rx_shift <= {rx_sync[1], rx_shift[7:1]};
        end
      end
    end
  end

  assign as_bus.rx_data  = rx_shift;
  assign as_bus.rx_dstrb = rx_dstrb;

endmodule

/* hdl/as_wb_bridge.sv */
module as_wb_bridge (
  input  logic sys_clk,
  input  logic rst_i,
  as_if.host   as_bus,
  wb_if.master wbm,
  output logic soft_reset_o
);
  import roach_pkg::*;

  localparam logic [2:0] S_CMD  = 3'd0;
  localparam logic [2:0] S_ADDR = 3'd1;
  localparam logic [2:0] S_DATA = 3'd2;
  localparam logic [2:0] S_BUS  = 3'd3;
  localparam logic [2:0] S_RESP = 3'd4;
  localparam logic [2:0] S_DONE = 3'd5;

  logic [2:0]           state;
  logic [7:0]           cmd;
  logic [1:0]           byte_cnt;
  logic                 cyc_q;
  logic [WB_ADDR_W-1:0] adr_q;
  logic [WB_DATA_W-1:0] wdat_q;
  logic [23:0]          resp_q; // status then read data, msb first
  logic [1:0]           resp_cnt;
  logic                 tx_go;

  assign tx_go           = (state == S_RESP) && !as_bus.tx_busy;
  assign as_bus.tx_dstrb = tx_go;
  assign as_bus.tx_data  = resp_q[23:16];

  assign wbm.cyc  = cyc_q;
  assign wbm.stb  = cyc_q;
  assign wbm.we   = (cmd == CMD_WRITE);
  assign wbm.adr  = adr_q;
  assign wbm.wdat = wdat_q;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      state        <= S_CMD;
      cmd          <= 8'h00;
      byte_cnt     <= '0;
      cyc_q        <= 1'b0;
      resp_cnt     <= '0;
      soft_reset_o <= 1'b0;
    end else begin
      soft_reset_o <= 1'b0;
      case (state)
        S_CMD: if (as_bus.rx_dstrb) begin
          cmd      <= as_bus.rx_data;
          byte_cnt <= '0;
          case (as_bus.rx_data)
            CMD_READ, CMD_WRITE: state <= S_ADDR;
            CMD_RESET: begin
              resp_q   <= {ST_OK, 16'h0000};
              resp_cnt <= 2'd1;
              state    <= S_RESP;
            end
            default: begin
              resp_q   <= {ST_BAD_CMD, 16'h0000};
              resp_cnt <= 2'd1;
              state    <= S_RESP;
            end
          endcase
        end
        S_ADDR: if (as_bus.rx_dstrb) begin
          adr_q    <= {adr_q[WB_ADDR_W-9:0], as_bus.rx_data};
          byte_cnt <= byte_cnt + 1'b1; // wraps to 0 after the last byte
          if (byte_cnt == 2'd3) begin
            if (cmd == CMD_WRITE) begin
              state <= S_DATA;
            end else begin
              state <= S_BUS;
              cyc_q <= 1'b1;
            end
          end
        end
        S_DATA: if (as_bus.rx_dstrb) begin
          wdat_q   <= {wdat_q[WB_DATA_W-9:0], as_bus.rx_data};
          byte_cnt <= byte_cnt + 1'b1;
          if (byte_cnt == 2'd1) begin
            byte_cnt <= '0;
            state    <= S_BUS;
            cyc_q    <= 1'b1;
          end
        end
        S_BUS: if (wbm.ack || wbm.err) begin
          cyc_q <= 1'b0;
          state <= S_RESP;
          if (wbm.err) begin
            resp_q   <= {ST_BUS_ERR, 16'h0000};
            resp_cnt <= 2'd1;
          end else if (cmd == CMD_WRITE) begin
            resp_q   <= {ST_OK, 16'h0000};
            resp_cnt <= 2'd1;
          end else begin
            resp_q   <= {ST_OK, wbm.rdat};
            resp_cnt <= 2'd3;
          end
        end
        S_RESP: if (tx_go) begin
          resp_q   <= {resp_q[15:0], 8'h00};
          resp_cnt <= resp_cnt - 1'b1;
          if (resp_cnt == 2'd1) state <= S_DONE;
        end
        S_DONE: if (!as_bus.tx_busy) begin
          // last byte fully on the line
          soft_reset_o <= (cmd == CMD_RESET);
          state        <= S_CMD;
        end
        default: state <= S_CMD;
      endcase
    end
  end

endmodule

/* hdl/wbs_arbiter.sv */
module wbs_arbiter (
  input  logic sys_clk,
  input  logic rst_i,
  wb_if.slave  wbm,
  wb_if.master wbs [roach_pkg::NUM_SLAVES]
);
  import roach_pkg::*;

  logic [NUM_SLAVES-1:0] hit;
  logic [NUM_SLAVES-1:0] ack_v;
  logic [NUM_SLAVES-1:0] err_v;
  logic [WB_DATA_W-1:0]  rdat_v [NUM_SLAVES];
  logic                  unmapped_err;
  logic [WB_DATA_W-1:0]  rdat_mux;

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave
    // windows do not overlap, so at most one hit
    assign hit[i] = (wbm.adr >= SLAVE_BASE[i]) && (wbm.adr <= SLAVE_HIGH[i]);

    assign wbs[i].cyc  = wbm.cyc & hit[i];
    assign wbs[i].stb  = wbm.stb & hit[i];
    assign wbs[i].we   = wbm.we;
    assign wbs[i].adr  = wbm.adr;
    assign wbs[i].wdat = wbm.wdat;

    assign ack_v[i]  = wbs[i].ack;
    assign err_v[i]  = wbs[i].err;
    assign rdat_v[i] = wbs[i].rdat;
  end

  always_comb begin
    rdat_mux = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (hit[i]) rdat_mux = rdat_v[i];
    end
  end

  // one-cycle error for addresses outside every window
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      unmapped_err <= 1'b0;
    end else begin
      unmapped_err <= wbm.cyc & wbm.stb & ~(|hit) & ~unmapped_err;
    end
  end

  assign wbm.rdat = rdat_mux;
  assign wbm.ack  = |(ack_v & hit);
  assign wbm.err  = unmapped_err | (|(err_v & hit));

endmodule

/* hdl/sys_block.sv */
module sys_block #(
  parameter logic [roach_pkg::WB_DATA_W-1:0] BOARD_ID  = 16'h0000,
  parameter logic [roach_pkg::WB_DATA_W-1:0] REV_MAJOR = 16'h0000,
  parameter logic [roach_pkg::WB_DATA_W-1:0] REV_MINOR = 16'h0000,
  parameter logic [roach_pkg::WB_DATA_W-1:0] REV_RCS   = 16'h0000
) (
  input  logic sys_clk,
  input  logic rst_i,
  wb_if.slave  wbs
);
  import roach_pkg::*;

  logic                 ack_q;
  logic                 access;
  logic [WB_DATA_W-1:0] scratch;
  logic [WB_DATA_W-1:0] rd_word;
  logic [WB_DATA_W-1:0] rdat_q;

  assign access = wbs.cyc & wbs.stb & ~ack_q;

  always_comb begin
    case (wbs.adr[2:0])
      REG_BOARD_ID:  rd_word = BOARD_ID;
      REG_REV_MAJOR: rd_word = REV_MAJOR;
      REG_REV_MINOR: rd_word = REV_MINOR;
      REG_REV_RCS:   rd_word = REV_RCS;
      REG_SCRATCH:   rd_word = scratch;
      default:       rd_word = '0;
    endcase
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_q   <= 1'b0;
      scratch <= '0;
    end else begin
      ack_q <= access;
      if (access && wbs.we && wbs.adr[2:0] == REG_SCRATCH) begin
        scratch <= wbs.wdat; // other writes acked and dropped
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (access) rdat_q <= rd_word;
  end

  assign wbs.ack  = ack_q;
  assign wbs.rdat = rdat_q;
  assign wbs.err  = 1'b0;

endmodule

/* hdl/bram_controller.sv */
module bram_controller #(
  parameter int RAM_WORDS = 2048
) (
  input  logic sys_clk,
  input  logic rst_i,
  wb_if.slave  wbs
);
  import roach_pkg::*;

  localparam int AW = $clog2(RAM_WORDS);

  logic [WB_DATA_W-1:0] mem [RAM_WORDS];
  logic [WB_DATA_W-1:0] rdat_q;
  logic                 ack_q;
  logic                 access;
  logic [AW-1:0]        waddr;

  assign access = wbs.cyc & wbs.stb & ~ack_q;
  assign waddr  = wbs.adr[AW-1:0]; // upper bits alias

  always_ff @(posedge sys_clk) begin
    if (rst_i) ack_q <= 1'b0;
    else       ack_q <= access;
  end

  always_ff @(posedge sys_clk) begin
    if (access) begin
      if (wbs.we) mem[waddr] <= wbs.wdat;
      rdat_q <= mem[waddr];
    end
  end

  assign wbs.ack  = ack_q;
  assign wbs.rdat = rdat_q;
  assign wbs.err  = 1'b0;

endmodule

/* hdl/toplevel.sv */
module toplevel #(
  parameter int CLOCK_RATE  = 100_000_000,
  parameter int BAUD        = 115_200,
  parameter int RESET_DELAY = 100,
  parameter int RAM_WORDS   = 2048,
  parameter logic [roach_pkg::WB_DATA_W-1:0] BOARD_ID  = 16'hb0a1,
  parameter logic [roach_pkg::WB_DATA_W-1:0] REV_MAJOR = 16'h0001,
  parameter logic [roach_pkg::WB_DATA_W-1:0] REV_MINOR = 16'h0000,
  parameter logic [roach_pkg::WB_DATA_W-1:0] REV_RCS   = 16'h0000
) (
  input  logic sys_clk,
  input  logic rst_i,
  input  logic serial_in_i,
  output logic serial_out_o
);
  import roach_pkg::*;

  logic sys_reset;
  logic soft_reset;

  as_if as_bus ();
  wb_if wbm_bus ();
  wb_if wbs_bus [NUM_SLAVES] ();

  reset_block #(.RESET_DELAY(RESET_DELAY)) reset_block_inst (
    .sys_clk(sys_clk), .rst_i(rst_i),
    .reset_req_i(soft_reset), .sys_reset_o(sys_reset)
  );

  serial_uart #(.CLOCK_RATE(CLOCK_RATE), .BAUD(BAUD)) serial_uart_inst (
    .sys_clk(sys_clk), .rst_i(sys_reset),
    .serial_in_i(serial_in_i), .serial_out_o(serial_out_o),
    .as_bus(as_bus)
  );

  // the only bus master
  as_wb_bridge as_wb_bridge_inst (
    .sys_clk(sys_clk), .rst_i(sys_reset),
    .as_bus(as_bus), .wbm(wbm_bus), .soft_reset_o(soft_reset)
  );

  wbs_arbiter wbs_arbiter_inst (
    .sys_clk(sys_clk), .rst_i(sys_reset),
    .wbm(wbm_bus), .wbs(wbs_bus)
  );

  sys_block #(
    .BOARD_ID(BOARD_ID), .REV_MAJOR(REV_MAJOR),
    .REV_MINOR(REV_MINOR), .REV_RCS(REV_RCS)
  ) sys_block_inst (
    .sys_clk(sys_clk), .rst_i(sys_reset), .wbs(wbs_bus[SLAVE_SYS])
  );

  bram_controller #(.RAM_WORDS(RAM_WORDS)) bram_controller_bootrom (
    .sys_clk(sys_clk), .rst_i(sys_reset), .wbs(wbs_bus[SLAVE_MEM])
  );

endmodule

/* dv/wbs_arbiter_props.sv */
module wbs_arbiter_props (
  input logic                              clk_i,
  input logic                              rst_i,
  input logic                              cyc_i,
  input logic                              stb_i,
  input logic                              ack_i,
  input logic                              err_i,
  input logic [roach_pkg::NUM_SLAVES-1:0]  slv_cyc_i
);
  timeunit 1ns;
  timeprecision 1ps;

  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (rst_i) stb_i |-> cyc_i)
    else $error("stb high without cyc on the master side");

  ack_err_excl: assert property (@(posedge clk_i) disable iff (rst_i) !(ack_i && err_i))
    else $error("ack and err high in the same cycle");

  // windows never overlap
  one_slave_cyc: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(slv_cyc_i))
    else $error("more than one slave cyc high");

  no_cyc_in_reset: assert property (@(posedge clk_i) rst_i |=> !cyc_i && slv_cyc_i == '0)
    else $error("cyc high while in reset");

endmodule

bind wbs_arbiter wbs_arbiter_props props0 (
  .clk_i(sys_clk),
  .rst_i(rst_i),
  .cyc_i(wbm.cyc),
  .stb_i(wbm.stb),
  .ack_i(wbm.ack),
  .err_i(wbm.err),
  .slv_cyc_i({wbs[roach_pkg::SLAVE_MEM].cyc, wbs[roach_pkg::SLAVE_SYS].cyc})
);

/* dv/toplevel_tb.sv */
module toplevel_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import roach_pkg::*;

  localparam int CLOCK_RATE  = 100_000_000;
  localparam int BAUD        = 10_000_000;
  localparam int BIT_CLKS    = CLOCK_RATE / BAUD;
  localparam int RESET_DELAY = 32;
  localparam int RAM_WORDS   = 256;
  localparam int RX_TIMEOUT  = 40 * BIT_CLKS;

  localparam logic [15:0] BOARD_ID  = 16'h5a17;
  localparam logic [15:0] REV_MAJOR = 16'h0002;
  localparam logic [15:0] REV_MINOR = 16'h0007;
  localparam logic [15:0] REV_RCS   = 16'h1c3e;

  localparam logic [31:0] MEM_BASE = 32'h0008_0000;
  localparam logic [31:0] NO_SLAVE = 32'h0004_0000; // outside every window

  typedef struct {
    logic [7:0]  cmd;
    logic [31:0] addr;
    logic [15:0] wdata;
    logic [7:0]  exp_status;
    logic [15:0] exp_rdata;
  } entry_t;

  logic        sys_clk;
  logic        rst_i;
  logic        serial_in_i;
  logic        serial_out_o;
  logic [31:0] lfsr_q;
  entry_t      table_q [$];

  toplevel #(
    .CLOCK_RATE(CLOCK_RATE), .BAUD(BAUD),
    .RESET_DELAY(RESET_DELAY), .RAM_WORDS(RAM_WORDS),
    .BOARD_ID(BOARD_ID), .REV_MAJOR(REV_MAJOR),
    .REV_MINOR(REV_MINOR), .REV_RCS(REV_RCS)
  ) dut0 (
    .sys_clk(sys_clk), .rst_i(rst_i),
    .serial_in_i(serial_in_i), .serial_out_o(serial_out_o)
  );

  always #5 sys_clk = ~sys_clk;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function logic [15:0] rand_word();
    logic [15:0] v;
    int          i;
    v = '0;
    for (i = 0; i < 16; i++) begin
      lfsr_q = lfsr_step(lfsr_q); // one step per bit
      v      = {v[14:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  task automatic add_entry(input logic [7:0] cmd, input logic [31:0] addr,
                           input logic [15:0] wdata, input logic [7:0] st,
                           input logic [15:0] rdata);
    entry_t e;
    e.cmd        = cmd;
    e.addr       = addr;
    e.wdata      = wdata;
    e.exp_status = st;
    e.exp_rdata  = rdata;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [15:0] id_vals [4];
    logic [15:0] mem_data [4];
    int          mem_off [4];
    int          i;
    id_vals  = '{BOARD_ID, REV_MAJOR, REV_MINOR, REV_RCS};
    mem_off  = '{16, 17, 127, 160};
    for (i = 0; i < 4; i++) begin
      add_entry(CMD_READ, 32'(i), 16'h0, ST_OK, id_vals[i]);
    end
    add_entry(CMD_WRITE, 32'(REG_SCRATCH), 16'hc3a5, ST_OK, 16'h0);
    add_entry(CMD_READ, 32'(REG_SCRATCH), 16'h0, ST_OK, 16'hc3a5);
    add_entry(CMD_WRITE, 32'(REG_BOARD_ID), 16'hffff, ST_OK, 16'h0); // read-only
    add_entry(CMD_READ, 32'(REG_BOARD_ID), 16'h0, ST_OK, BOARD_ID);
    for (i = 0; i < 4; i++) begin
      mem_data[i] = rand_word();
      add_entry(CMD_WRITE, MEM_BASE + mem_off[i], mem_data[i], ST_OK, 16'h0);
    end
    for (i = 0; i < 4; i++) begin
      add_entry(CMD_READ, MEM_BASE + mem_off[i], 16'h0, ST_OK, mem_data[i]);
    end
    add_entry(CMD_READ, MEM_BASE + mem_off[0] + RAM_WORDS, 16'h0, ST_OK, mem_data[0]);
    add_entry(CMD_READ, NO_SLAVE, 16'h0, ST_BUS_ERR, 16'h0);
    add_entry(CMD_WRITE, NO_SLAVE, 16'h1234, ST_BUS_ERR, 16'h0);
    add_entry(CMD_READ, 32'(REG_REV_MAJOR), 16'h0, ST_OK, REV_MAJOR);
    add_entry(8'h7c, 32'h0, 16'h0, ST_BAD_CMD, 16'h0);
    add_entry(CMD_RESET, 32'h0, 16'h0, ST_OK, 16'h0);
    add_entry(CMD_READ, 32'(REG_SCRATCH), 16'h0, ST_OK, 16'h0000);
    add_entry(CMD_READ, MEM_BASE + mem_off[1], 16'h0, ST_OK, mem_data[1]); // survives reset
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    int         i;
    frame = {1'b1, b, 1'b0};
    for (i = 0; i < 10; i++) begin
      @(negedge sys_clk);
      serial_in_i = frame[i]; // lsb first after start bit
      repeat (BIT_CLKS - 1) @(negedge sys_clk);
    end
  endtask

  task automatic recv_byte(output logic [7:0] b);
    int n;
    int i;
    n = 0;
    @(negedge sys_clk);
    while (serial_out_o !== 1'b0) begin
      if (n == RX_TIMEOUT) begin
        abort_run("timed out waiting for a start bit on serial_out_o");
      end
      n++;
      @(negedge sys_clk);
    end
    repeat (BIT_CLKS / 2) @(negedge sys_clk); // middle of start bit
    check("serial_out_o start bit", serial_out_o, 1'b0);
    for (i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge sys_clk);
      b[i] = serial_out_o;
    end
    repeat (BIT_CLKS) @(negedge sys_clk);
    check("serial_out_o stop bit", serial_out_o, 1'b1);
  endtask

  task automatic expect_idle(input int cycles);
    int i;
    for (i = 0; i < cycles; i++) begin
      @(negedge sys_clk);
      check("serial_out_o idle", serial_out_o, 1'b1);
    end
  endtask

  task automatic run_entry(input int idx, input entry_t e);
    logic [7:0] st;
    logic [7:0] hi;
    logic [7:0] lo;
    int         i;
    send_byte(e.cmd);
    if (e.cmd == CMD_READ || e.cmd == CMD_WRITE) begin
      for (i = 3; i >= 0; i--) send_byte(e.addr[8*i +: 8]);
      if (e.cmd == CMD_WRITE) begin
        send_byte(e.wdata[15:8]);
        send_byte(e.wdata[7:0]);
      end
    end
    recv_byte(st);
    check($sformatf("status[%0d]", idx), st, e.exp_status);
    if (e.cmd == CMD_READ && e.exp_status == ST_OK) begin
      recv_byte(hi);
      recv_byte(lo);
      check($sformatf("rdata[%0d]", idx), {hi, lo}, e.exp_rdata);
    end
    expect_idle(2 * BIT_CLKS); // nothing after the response
    if (e.cmd == CMD_RESET) begin
      repeat (RESET_DELAY + 20) @(negedge sys_clk);
    end
  endtask

  initial begin
    sys_clk     = 1'b0;
    rst_i       = 1'b1;
    serial_in_i = 1'b1;
    lfsr_q      = 32'h015b_63a8;
    build_table();
    repeat (2) @(negedge sys_clk);
    rst_i = 1'b0;
    repeat (RESET_DELAY + 10) @(negedge sys_clk); // reset_block stretch
    check("serial_out_o after reset", serial_out_o, 1'b1);
    foreach (table_q[i]) begin
      run_entry(i, table_q[i]);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* build.f */
hdl/roach_pkg.sv
hdl/wb_if.sv
hdl/as_if.sv
hdl/reset_block.sv
hdl/serial_uart.sv
hdl/as_wb_bridge.sv
hdl/wbs_arbiter.sv
hdl/sys_block.sv
hdl/bram_controller.sv
hdl/toplevel.sv
dv/wbs_arbiter_props.sv
dv/toplevel_tb.sv

/* Bender.yml */
package:
  name: roach_ctrl

sources:
  - hdl/roach_pkg.sv
  - hdl/wb_if.sv
  - hdl/as_if.sv
  - hdl/reset_block.sv
  - hdl/serial_uart.sv
  - hdl/as_wb_bridge.sv
  - hdl/wbs_arbiter.sv
  - hdl/sys_block.sv
  - hdl/bram_controller.sv
  - hdl/toplevel.sv
  - target: test
    files:
      - dv/wbs_arbiter_props.sv
      - dv/toplevel_tb.sv
